//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cce_top
FILELIST = vlog.f
PASS_MSG = Testbench passed

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- bench/tb_cce_top.sv
// Testbench for cce_top that checks random traffic cycle by cycle against a queue and program model
`timescale 1ns/1ps

module tb_cce_top;

   // Test lengths add up to about 1300 cycles and the limit leaves a wide margin
   localparam int TIMEOUT_CYC = 4000;

   logic clk;
   logic arst_n;
   logic msg_v;
   logic [cce_pkg::MSG_W-1:0] msg;
   logic msg_ready;
   logic cmd_ready;
   logic busy;
   logic cmd_v;
   logic [cce_pkg::MSG_W-1:0] cmd;

   // Model queues mirror the FIFO contents
   logic [cce_pkg::PAYLOAD_W-1:0] mq [cce_pkg::NUM_SRC_Q][$];
   logic [cce_pkg::PAYLOAD_W-1:0] mpay;
   int mpc = 0;
   logic [31:0] rng = 32'hec3;
   int checks = 0;
   int errors = 0;
   int dut_xfers = 0;
   int cycles = 0;

   tb_clock i_tb_clock (.clk_o(clk));

   cce_top i_cce_top (
      .clk_i       (clk),
      .arst_n_i    (arst_n),
      .msg_v_i     (msg_v),
      .msg_i       (msg),
      .msg_ready_o (msg_ready),
      .cmd_ready_i (cmd_ready),
      .busy_i      (busy),
      .cmd_v_o     (cmd_v),
      .cmd_o       (cmd)
   );

   // 32-bit xorshift step
   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // Random type and payload with one type optionally left out
   function automatic logic [cce_pkg::MSG_W-1:0] rand_msg(input int avoid);
      logic [31:0] r;
      logic [cce_pkg::SRC_Q_W-1:0] t;
      r = next_rand();
      t = r[31:30];
      if (int'(t) == avoid) t = t + 2'd1;
      return {t, r[cce_pkg::PAYLOAD_W-1:0]};
   endfunction

   // Program sits on a pop of an empty queue
   function automatic logic queue_stuck();
      return (mpc != 8) && (mpc % 2 == 0) && (mq[mpc / 2].size() == 0);
   endfunction

   task automatic report_mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
      errors++;
      $display("Fail %s: got %h, expected %h", sig, got, exp);
   endtask

   // Compare one cycle and step the model as the program would
   task automatic check_cycle();
      logic [cce_pkg::SRC_Q_W-1:0] mtype;
      logic exp_ready;
      logic exp_cmd_v;
      logic [cce_pkg::MSG_W-1:0] exp_cmd;
      int qi;
      mtype = msg[cce_pkg::MSG_W-1 -: cce_pkg::SRC_Q_W];
      qi = mpc / 2;
      exp_ready = (mq[mtype].size() < cce_pkg::FIFO_DEPTH);
      exp_cmd_v = (mpc != 8) && (mpc % 2 == 1) && !busy;
      exp_cmd = {qi[1:0], mpay};
      checks += 2;
      if (msg_ready !== exp_ready) report_mismatch("msg_ready_o", 32'(msg_ready), 32'(exp_ready));
      if (cmd_v !== exp_cmd_v) report_mismatch("cmd_v_o", 32'(cmd_v), 32'(exp_cmd_v));
      // Command holds the round index and last popped payload until taken
      if (exp_cmd_v) begin
         checks++;
         if (cmd !== exp_cmd) report_mismatch("cmd_o", 32'(cmd), 32'(exp_cmd));
      end
      if (cmd_v && cmd_ready) dut_xfers++;
      // Pop decision uses the queue as it was at the start of the cycle
      if (mpc == 8) begin
         if (!busy) mpc = 0;
      end else if (mpc % 2 == 0) begin
         if (!busy && mq[qi].size() != 0) begin
            mpay = mq[qi].pop_front();
            mpc++;
         end
      end else if (!busy && cmd_ready) begin
         mpc++;
      end
      if (msg_v && exp_ready) mq[mtype].push_back(msg[cce_pkg::PAYLOAD_W-1:0]);
   endtask

   // Drive just after the rising edge and check at the falling edge
   task automatic run_cycle(input logic v, input logic [cce_pkg::MSG_W-1:0] m,
                            input logic rdy, input logic bsy);
      @(posedge clk);
      #10;
      msg_v = v;
      msg = m;
      cmd_ready = rdy;
      busy = bsy;
      @(negedge clk);
      check_cycle();
   endtask

   // Percentages set message rate and ready rate
   task automatic random_traffic(input int n, input int v_pct, input int rdy_pct,
                                 input logic bsy, input int avoid);
      logic v;
      logic rdy;
      repeat (n) begin
         v = (next_rand() % 100) < v_pct;
         rdy = (next_rand() % 100) < rdy_pct;
         run_cycle(v, rand_msg(avoid), rdy, bsy);
      end
   endtask

   task automatic report_test(input int n, input string name, input int base);
      $display("Test %0d %s: %0d errors", n, name, errors - base);
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYC) begin
         $display("Run stopped by timeout after %0d cycles", cycles);
         $display("Testbench failed");
         $finish;
      end
   end

   initial begin
      int base;
      int stuck_q;
      int mark;
      arst_n = 1'b0;
      msg_v = 1'b0;
      msg = '0;
      cmd_ready = 1'b0;
      busy = 1'b0;
      repeat (2) @(posedge clk);
      #10 arst_n = 1'b1;

      // Idle outputs and ready for every type
      base = errors;
      for (int t = 0; t < 4; t++) run_cycle(1'b0, {2'(t), 14'h0}, 1'b1, 1'b0);
      report_test(1, "reset state", base);

      base = errors;
      random_traffic(300, 60, 100, 1'b0, -1);
      report_test(2, "round order", base);

      // Drain until the program waits on an empty queue and then starve it
      base = errors;
      while (!queue_stuck()) run_cycle(1'b0, '0, 1'b1, 1'b0);
      stuck_q = mpc / 2;
      mark = dut_xfers;
      random_traffic(150, 60, 100, 1'b0, stuck_q);
      if (dut_xfers != mark) begin
         errors++;
         $display("Commands appeared while queue %0d was empty", stuck_q);
      end
      run_cycle(1'b1, {2'(stuck_q), 14'h1a5}, 1'b1, 1'b0);
      mark = dut_xfers;
      random_traffic(100, 50, 100, 1'b0, -1);
      if (dut_xfers == mark) begin
         errors++;
         $display("No command followed the refill of queue %0d", stuck_q);
      end
      report_test(3, "empty queue", base);

      base = errors;
      random_traffic(400, 70, 30, 1'b0, -1);
      report_test(4, "back-pressure", base);

      // Busy window followed by release
      base = errors;
      mark = dut_xfers;
      random_traffic(100, 60, 50, 1'b1, -1);
      if (dut_xfers != mark) begin
         errors++;
         $display("A command transferred while busy was high");
      end
      random_traffic(200, 50, 100, 1'b0, -1);
      if (dut_xfers == mark) begin
         errors++;
         $display("Commands did not resume after busy was released");
      end
      report_test(5, "busy hold", base);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) $display("Testbench passed");
      else $display("Testbench failed");
      $finish;
   end

endmodule

//--- bench/tb_clock.sv
// Free-running testbench clock, instantiated once by the testbench top with a 100 ns period
`timescale 1ns/1ps

module tb_clock (
   output logic clk_o
);

   // Half of the 100 ns period
   localparam time HALF_PERIOD = 50ns;

   initial clk_o = 1'b0;

   always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule

//--- rtl/cce_exec.sv
// Microcode executor that steps the program, pops source queues and drives the command output
`timescale 1ns/1ps

module cce_exec (
   input  logic                                                clk_i,
   input  logic                                                arst_n_i,
   input  logic [cce_pkg::NUM_SRC_Q-1:0]                       src_v_i,
   input  logic [cce_pkg::NUM_SRC_Q-1:0][cce_pkg::PAYLOAD_W-1:0] src_data_i,
   input  logic                                                cmd_ready_i,
   input  logic                                                busy_i,
   output logic [cce_pkg::NUM_SRC_Q-1:0]                       src_pop_o,
   output logic                                                cmd_v_o,
   output logic [cce_pkg::MSG_W-1:0]                           cmd_o
);

   // Program counter and its next value
   logic [cce_pkg::PC_W-1:0]      pc_r;
   logic [cce_pkg::PC_W-1:0]      pc_next;
   // Header popped by the last popq
   logic [cce_pkg::PAYLOAD_W-1:0] payload_r;
   cce_pkg::cce_decoded_s         decoded;
   logic                          stall;

   cce_inst_decode i_cce_inst_decode (
      .pc_i      (pc_r),
      .decoded_o (decoded)
   );

   cce_inst_stall i_cce_inst_stall (
      .decoded_i   (decoded),
      .src_v_i     (src_v_i),
      .cmd_ready_i (cmd_ready_i),
      .busy_i      (busy_i),
      .stall_o     (stall)
   );

   // Hold on stall, branch on jump or step to the next word
   always_comb begin
      if (stall) pc_next = pc_r;
      else if (decoded.jump) pc_next = decoded.jump_target;
      else pc_next = pc_r + cce_pkg::PC_W'(1);
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) pc_r <= '0;
      else pc_r <= pc_next;
   end

   // Header capture at the same edge as the pop
   always_ff @(posedge clk_i) begin
      if (decoded.popq && !stall) payload_r <= src_data_i[decoded.popq_qsel];
   end

   // One pop strobe for an unstalled popq only
   always_comb begin
      src_pop_o = '0;
      if (decoded.popq && !stall) src_pop_o[decoded.popq_qsel] = 1'b1;
   end

   // Command valid drops while busy so nothing transfers
   assign cmd_v_o = decoded.send & ~busy_i;
   assign cmd_o   = {decoded.src_code, payload_r};

   a_pc_in_rom: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      pc_r < cce_pkg::PC_W'(cce_pkg::ROM_DEPTH));
   // A held command keeps its contents until accepted
   a_cmd_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (cmd_v_o && !cmd_ready_i) |=> $stable(cmd_o));

endmodule

//--- rtl/cce_inst_decode.sv
// Microcode ROM with the fixed program, decodes the current word into control strobes
`timescale 1ns/1ps

module cce_inst_decode (
   input  logic [cce_pkg::PC_W-1:0] pc_i,
   output cce_pkg::cce_decoded_s    decoded_o
);

   // Current instruction word
   cce_pkg::cce_inst_u inst;

   // Build a pop-header word for one queue
   function automatic cce_pkg::cce_inst_u popq_inst(input cce_pkg::cce_src_q_e qsel);
      cce_pkg::cce_inst_u w;
      w        = '0;
      w.q.op   = cce_pkg::e_op_popq;
      w.q.qsel = qsel;
      return w;
   endfunction

   // Build a send word with its source code
   function automatic cce_pkg::cce_inst_u send_inst(input logic [cce_pkg::SRC_Q_W-1:0] code);
      cce_pkg::cce_inst_u w;
      w            = '0;
      w.f.op       = cce_pkg::e_op_send;
      w.f.src_code = code;
      return w;
   endfunction

   // Build a jump word
   function automatic cce_pkg::cce_inst_u jump_inst(input logic [cce_pkg::PC_W-1:0] target);
      cce_pkg::cce_inst_u w;
      w          = '0;
      w.f.op     = cce_pkg::e_op_jump;
      w.f.target = target;
      return w;
   endfunction

   // Program ROM, one pop and one send per queue then back to the start
   always_comb begin
      inst = '0;
      case (pc_i)
         cce_pkg::PC_W'(0): inst = popq_inst(cce_pkg::e_src_q_lce_req);
         cce_pkg::PC_W'(1): inst = send_inst(2'd0);
         cce_pkg::PC_W'(2): inst = popq_inst(cce_pkg::e_src_q_lce_resp);
         cce_pkg::PC_W'(3): inst = send_inst(2'd1);
         cce_pkg::PC_W'(4): inst = popq_inst(cce_pkg::e_src_q_mem_resp);
         cce_pkg::PC_W'(5): inst = send_inst(2'd2);
         cce_pkg::PC_W'(6): inst = popq_inst(cce_pkg::e_src_q_pending);
         cce_pkg::PC_W'(7): inst = send_inst(2'd3);
         cce_pkg::PC_W'(8): inst = jump_inst(cce_pkg::PC_W'(0));
         // Outside the program, the all-zero word is invalid
         default: inst = '0;
      endcase
   end

   // Opcode picks which view of the word is meaningful
   always_comb begin
      decoded_o             = '0;
      decoded_o.v           = (inst.q.op != 2'd0);
      decoded_o.popq        = (inst.q.op == cce_pkg::e_op_popq);
      decoded_o.send        = (inst.f.op == cce_pkg::e_op_send);
      decoded_o.jump        = (inst.f.op == cce_pkg::e_op_jump);
      decoded_o.popq_qsel   = inst.q.qsel;
      decoded_o.src_code    = inst.f.src_code;
      decoded_o.jump_target = inst.f.target;
   end

endmodule

//--- rtl/cce_inst_stall.sv
// Stall unit, blocks all state changes and replays the current instruction when a resource is missing
`timescale 1ns/1ps

module cce_inst_stall (
   input  cce_pkg::cce_decoded_s         decoded_i,
   // Source queue valids, indexed by queue select
   input  logic [cce_pkg::NUM_SRC_Q-1:0] src_v_i,
   // Command output readiness
   input  logic                          cmd_ready_i,
   // External busy, holds off all microcode
   input  logic                          busy_i,
   output logic                          stall_o
);

   // Per-cause stall terms
   logic popq_stall;
   logic send_stall;
   logic busy_stall;

   // Pop header waits for the selected queue to hold an entry
   assign popq_stall = decoded_i.popq & ~src_v_i[decoded_i.popq_qsel];

   // Send waits on the ready side of the valid and ready pair
   assign send_stall = decoded_i.send & ~cmd_ready_i;

   // External busy blocks every instruction, jumps included
   assign busy_stall = busy_i;

   always_comb begin
      stall_o = 1'b0;

      // Resource not ready for the instruction itself
      stall_o |= popq_stall;
      stall_o |= send_stall;

      // Unit-wide hold
      stall_o |= busy_stall;

      // Invalid words never stall
      stall_o &= decoded_i.v;
   end

endmodule

//--- rtl/cce_msg_router.sv
// Input message router that steers each message to the source FIFO named by its type field
`timescale 1ns/1ps

module cce_msg_router (
   input  logic                          msg_v_i,
   input  logic [cce_pkg::MSG_W-1:0]     msg_i,
   input  logic [cce_pkg::NUM_SRC_Q-1:0] fifo_full_i,
   output logic                          msg_ready_o,
   output logic [cce_pkg::NUM_SRC_Q-1:0] fifo_push_o,
   output logic [cce_pkg::PAYLOAD_W-1:0] fifo_data_o
);

   // Queue type sits in the top bits of the message
   logic [cce_pkg::SRC_Q_W-1:0] msg_type;

   assign msg_type = msg_i[cce_pkg::MSG_W-1 -: cce_pkg::SRC_Q_W];

   // Ready follows only the target FIFO and ignores the valid
   assign msg_ready_o = ~fifo_full_i[msg_type];

   // Payload goes to every FIFO and only the push selects one
   assign fifo_data_o = msg_i[cce_pkg::PAYLOAD_W-1:0];

   always_comb begin
      fifo_push_o = '0;
      // One-hot push on an accepted message
      if (msg_v_i && msg_ready_o) begin
         fifo_push_o[msg_type] = 1'b1;
      end
   end

endmodule

//--- rtl/cce_pkg.sv
// Shared widths, depths, encodings and instruction types for the coherence-engine front end
package cce_pkg;

   // Source queue count and index width
   localparam int NUM_SRC_Q  = 4;
   localparam int SRC_Q_W    = 2;

   // Message layout: queue type or source code on top, payload below
   localparam int PAYLOAD_W  = 14;
   localparam int MSG_W      = 16;

   // Source FIFO sizing
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = 2;
   localparam int FIFO_CNT_W = 3;

   // Microcode store
   localparam int PC_W       = 4;
   localparam int ROM_DEPTH  = 9;
   localparam int INST_W     = 16;

   // Source queue select, also the type field of an incoming message
   typedef enum logic [SRC_Q_W-1:0] {
      e_src_q_lce_req  = 2'd0,
      e_src_q_lce_resp = 2'd1,
      e_src_q_mem_resp = 2'd2,
      e_src_q_pending  = 2'd3
   } cce_src_q_e;

   // Opcodes; zero is left unused and decodes as an invalid word
   typedef enum logic [1:0] {
      e_op_popq = 2'd1,
      e_op_send = 2'd2,
      e_op_jump = 2'd3
   } cce_op_e;

   // Queue view of an instruction word
   typedef struct packed {
      cce_op_e               op;
      cce_src_q_e            qsel;
      logic [11:0]           spare;
   } cce_inst_queue_s;

   // Flow view of an instruction word, send and jump
   typedef struct packed {
      cce_op_e               op;
      logic [SRC_Q_W-1:0]    src_code;
      logic [PC_W-1:0]       target;
      logic [7:0]            spare;
   } cce_inst_flow_s;

   // One 16-bit microcode word read through either view
   typedef union packed {
      cce_inst_queue_s q;
      cce_inst_flow_s  f;
   } cce_inst_u;

   // Decoded control strobes and fields
   typedef struct packed {
      logic                  v;
      logic                  popq;
      logic                  send;
      logic                  jump;
      cce_src_q_e            popq_qsel;
      logic [SRC_Q_W-1:0]    src_code;
      logic [PC_W-1:0]       jump_target;
   } cce_decoded_s;

endpackage

//--- rtl/cce_src_fifo.sv
// Source queue FIFO, a small circular buffer that holds message payloads for the executor
`timescale 1ns/1ps

module cce_src_fifo (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   input  logic                          push_i,
   input  logic [cce_pkg::PAYLOAD_W-1:0] data_i,
   input  logic                          pop_i,
   output logic [cce_pkg::PAYLOAD_W-1:0] data_o,
   output logic                          v_o,
   output logic                          full_o
);

   // Payload storage
   logic [cce_pkg::PAYLOAD_W-1:0] mem [cce_pkg::FIFO_DEPTH];
   // Read and write pointers wrap at the depth
   logic [cce_pkg::FIFO_PTR_W-1:0] rd_ptr;
   logic [cce_pkg::FIFO_PTR_W-1:0] wr_ptr;
   // Occupancy, 0 up to the depth
   logic [cce_pkg::FIFO_CNT_W-1:0] count;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) wr_ptr <= wr_ptr + cce_pkg::FIFO_PTR_W'(1);
         if (pop_i) rd_ptr <= rd_ptr + cce_pkg::FIFO_PTR_W'(1);
         // Count holds on simultaneous push and pop
         if (push_i && !pop_i) count <= count + cce_pkg::FIFO_CNT_W'(1);
         else if (pop_i && !push_i) count <= count - cce_pkg::FIFO_CNT_W'(1);
      end
   end

   // Storage write
   always_ff @(posedge clk_i) begin
      if (push_i) mem[wr_ptr] <= data_i;
   end

   // Head entry and status flags
   assign data_o = mem[rd_ptr];
   assign v_o    = (count != '0);
   assign full_o = (count == cce_pkg::FIFO_CNT_W'(cce_pkg::FIFO_DEPTH));

   // Router must respect full, executor must respect valid
   a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i) push_i |-> !full_o);
   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i) pop_i |-> v_o);

endmodule

//--- rtl/cce_top.sv
// Coherence-engine front end top, router and four source FIFOs feeding the microcode executor
`timescale 1ns/1ps

module cce_top (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   input  logic                          msg_v_i,
   input  logic [cce_pkg::MSG_W-1:0]     msg_i,
   output logic                          msg_ready_o,
   input  logic                          cmd_ready_i,
   input  logic                          busy_i,
   output logic                          cmd_v_o,
   output logic [cce_pkg::MSG_W-1:0]     cmd_o
);

   // Router to FIFO side
   logic [cce_pkg::NUM_SRC_Q-1:0]                         fifo_push;
   logic [cce_pkg::PAYLOAD_W-1:0]                         fifo_data;
   logic [cce_pkg::NUM_SRC_Q-1:0]                         fifo_full;
   // FIFO to executor side
   logic [cce_pkg::NUM_SRC_Q-1:0]                         fifo_v;
   logic [cce_pkg::NUM_SRC_Q-1:0][cce_pkg::PAYLOAD_W-1:0] fifo_head;
   logic [cce_pkg::NUM_SRC_Q-1:0]                         fifo_pop;

   cce_msg_router i_cce_msg_router (
      .msg_v_i     (msg_v_i),
      .msg_i       (msg_i),
      .fifo_full_i (fifo_full),
      .msg_ready_o (msg_ready_o),
      .fifo_push_o (fifo_push),
      .fifo_data_o (fifo_data)
   );

   // One FIFO per source queue, index matches the queue select
   for (genvar q = 0; q < cce_pkg::NUM_SRC_Q; q++) begin : g_src_fifo
      cce_src_fifo i_cce_src_fifo (
         .clk_i    (clk_i),
         .arst_n_i (arst_n_i),
         .push_i   (fifo_push[q]),
         .data_i   (fifo_data),
         .pop_i    (fifo_pop[q]),
         .data_o   (fifo_head[q]),
         .v_o      (fifo_v[q]),
         .full_o   (fifo_full[q])
      );
   end

   cce_exec i_cce_exec (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .src_v_i     (fifo_v),
      .src_data_i  (fifo_head),
      .cmd_ready_i (cmd_ready_i),
      .busy_i      (busy_i),
      .src_pop_o   (fifo_pop),
      .cmd_v_o     (cmd_v_o),
      .cmd_o       (cmd_o)
   );

endmodule

//--- vlog.f
rtl/cce_pkg.sv
rtl/cce_msg_router.sv
rtl/cce_src_fifo.sv
rtl/cce_inst_decode.sv
rtl/cce_inst_stall.sv
rtl/cce_exec.sv
rtl/cce_top.sv
bench/tb_clock.sv
bench/tb_cce_top.sv
